// ==== compile.f ====
+incdir+sim
design/mul_array_pkg.sv
design/apb_operand_feeder.sv
design/mul_lane.sv
design/product_collector.sv
design/mul_array_top.sv
sim/tb_mul_array.sv

// ==== design/apb_operand_feeder.sv ====
// APB slave of the multiply array: operand registers, start snapshot and launch, read-back mux
`timescale 1ns/100ps

module apb_operand_feeder #(
    parameter int NUM_LANES = 4
) (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  logic                                                 psel,
    input  logic                                                 penable,
    input  logic                                                 pwrite,
    input  logic [mul_array_pkg::apb_addr_w-1:0]                 paddr,
    input  logic [mul_array_pkg::apb_data_w-1:0]                 pwdata,
    output logic [mul_array_pkg::apb_data_w-1:0]                 prdata,
    output logic                                                 pready,
    output logic                                                 pslverr,
    input  logic [NUM_LANES*mul_array_pkg::product_w-1:0]        results,
    input  logic                                                 busy,
    input  logic                                                 done,
    output logic                                                 launch,
    output logic [mul_array_pkg::num_data_words*mul_array_pkg::operand_w-1:0] data_words,
    output logic [NUM_LANES*$clog2(mul_array_pkg::num_data_words)-1:0] lane_sel,
    output logic [NUM_LANES*mul_array_pkg::operand_w-1:0]        lane_coef
);
    import mul_array_pkg::*;

    localparam int sel_w = $clog2(num_data_words);

    logic                  access;
    logic                  aligned;
    logic [apb_addr_w-1:0] data_off;
    logic [apb_addr_w-1:0] cfg_off;
    logic [apb_addr_w-1:0] res_off;
    logic [1:0]            data_idx;
    logic [2:0]            cfg_idx;
    logic [2:0]            res_idx;
    logic                  is_data;
    logic                  is_cfg;
    logic                  is_ctrl;
    logic                  is_status;
    logic                  is_result;
    logic                  mapped;
    logic                  wr_en;
    logic                  start_wr;

    // Host-visible registers and the copies taken at start
    logic [operand_w-1:0]  data_q    [num_data_words];
    logic [operand_w-1:0]  data_snap [num_data_words];
    lane_cfg_u             cfg_q     [NUM_LANES];
    lane_cfg_u             cfg_snap  [NUM_LANES];

    // Address decode, offsets wrap below each base so the range test fails there
    assign access    = psel && penable;
    assign aligned   = (paddr[1:0] == 2'b00);
    assign data_off  = paddr - addr_data_base;
    assign cfg_off   = paddr - addr_cfg_base;
    assign res_off   = paddr - addr_result_base;
    assign data_idx  = data_off[3:2];
    assign cfg_idx   = cfg_off[4:2];
    assign res_idx   = res_off[4:2];
    assign is_data   = aligned && (data_off[apb_addr_w-1:2] < num_data_words);
    assign is_cfg    = aligned && (cfg_off[apb_addr_w-1:2] < NUM_LANES);
    assign is_result = aligned && (res_off[apb_addr_w-1:2] < NUM_LANES);
    assign is_ctrl   = (paddr == addr_ctrl);
    assign is_status = (paddr == addr_status);
    assign mapped    = is_data || is_cfg || is_ctrl || is_status || is_result;

    assign wr_en     = access && pwrite;
    assign start_wr  = wr_en && is_ctrl && pwdata[0];

    // No wait states
    assign pready  = 1'b1;
    // Status and result words are read only
    assign pslverr = access && (!mapped || (pwrite && (is_status || is_result)));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            launch <= 1'b0;
            for (int i = 0; i < num_data_words; i++) begin
                data_q[i]    <= '0;
                data_snap[i] <= '0;
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                cfg_q[i].raw    <= '0;
                cfg_snap[i].raw <= '0;
            end
        end else begin
            launch <= start_wr;
            if (wr_en && is_data) begin
                data_q[data_idx] <= pwdata[operand_w-1:0];
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (wr_en && is_cfg && cfg_idx == i) begin
                    cfg_q[i].raw <= pwdata;
                end
            end
            // Freeze operands for the operation being launched
            if (start_wr) begin
                data_snap <= data_q;
                cfg_snap  <= cfg_q;
            end
        end
    end

    // Lane-facing outputs come from the snapshot only
    always_comb begin
        for (int i = 0; i < num_data_words; i++) begin
            data_words[i*operand_w +: operand_w] = data_snap[i];
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_sel[i*sel_w +: sel_w]         = cfg_snap[i].fields.sel;
            lane_coef[i*operand_w +: operand_w] = cfg_snap[i].fields.coef;
        end
    end

    // Read mux; control reads back as zero, status is {done, busy} in bits 1:0
    always_comb begin
        prdata = '0;
        if (is_data) begin
            prdata = apb_data_w'(data_q[data_idx]);
        end else if (is_cfg) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (cfg_idx == i) begin
                    prdata = cfg_q[i].raw;
                end
            end
        end else if (is_status) begin
            prdata = apb_data_w'({done, busy});
        end else if (is_result) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (res_idx == i) begin
                    prdata = results[i*product_w +: product_w];
                end
            end
        end
    end

    // Starts are at least two cycles apart on APB
    a_launch_single: assert property (@(posedge clk) disable iff (!arst_n) launch |=> !launch)
        else $error("launch held for more than one cycle");

endmodule

// ==== design/mul_array_pkg.sv ====
// Shared constants, APB register map and lane configuration types, imported by every design module
package mul_array_pkg;

    // Bus and datapath widths
    localparam int apb_addr_w     = 8;
    localparam int apb_data_w     = 32;
    localparam int operand_w      = 16;
    localparam int product_w      = 32;
    localparam int num_data_words = 4;

    // Register map, one 32-bit word per address, word step of 4
    localparam logic [apb_addr_w-1:0] addr_data_base   = 8'h00;
    localparam logic [apb_addr_w-1:0] addr_cfg_base    = 8'h10;
    localparam logic [apb_addr_w-1:0] addr_ctrl        = 8'h40;
    localparam logic [apb_addr_w-1:0] addr_status      = 8'h44;
    localparam logic [apb_addr_w-1:0] addr_result_base = 8'h80;

    // Per-lane configuration word as seen by the lane
    typedef struct packed {
        logic [13:0]          reserved;
        logic [1:0]           sel;
        logic [operand_w-1:0] coef;
    } lane_cfg_t;

    // Same word, written from the bus as raw and read out as fields
    typedef union packed {
        logic [apb_data_w-1:0] raw;
        lane_cfg_t             fields;
    } lane_cfg_u;

endpackage

// ==== design/mul_array_top.sv ====
// Multiply array top level: APB feeder, generated multiply lanes and product collector
`timescale 1ns/100ps

module mul_array_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [mul_array_pkg::apb_addr_w-1:0]  paddr,
    input  logic [mul_array_pkg::apb_data_w-1:0]  pwdata,
    output logic [mul_array_pkg::apb_data_w-1:0]  prdata,
    output logic                                  pready,
    output logic                                  pslverr
);
    import mul_array_pkg::*;

    localparam int sel_w = $clog2(num_data_words);

    logic                                  launch;
    logic [num_data_words*operand_w-1:0]   data_words;
    logic [NUM_LANES*sel_w-1:0]            lane_sel;
    logic [NUM_LANES*operand_w-1:0]        lane_coef;
    logic [NUM_LANES-1:0]                  prod_valid;
    logic [NUM_LANES*product_w-1:0]        product;
    logic [NUM_LANES*product_w-1:0]        results;
    logic                                  busy;
    logic                                  done;

    // Config and result windows hold eight words each
    if (NUM_LANES < 1 || NUM_LANES > 8) begin : gen_lane_check
        $error("NUM_LANES must be between 1 and 8");
    end

    apb_operand_feeder #(
        .NUM_LANES (NUM_LANES)
    ) u_feeder (
        .clk        (clk),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .results    (results),
        .busy       (busy),
        .done       (done),
        .launch     (launch),
        .data_words (data_words),
        .lane_sel   (lane_sel),
        .lane_coef  (lane_coef)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lanes
        mul_lane u_lane (
            .clk        (clk),
            .arst_n     (arst_n),
            .launch     (launch),
            .data_words (data_words),
            .lane_sel   (lane_sel[i*sel_w +: sel_w]),
            .lane_coef  (lane_coef[i*operand_w +: operand_w]),
            .prod_valid (prod_valid[i]),
            .product    (product[i*product_w +: product_w])
        );
    end

    product_collector #(
        .NUM_LANES (NUM_LANES)
    ) u_collector (
        .clk        (clk),
        .arst_n     (arst_n),
        .launch     (launch),
        .prod_valid (prod_valid),
        .product    (product),
        .results    (results),
        .busy       (busy),
        .done       (done)
    );

endmodule

// ==== design/mul_lane.sv ====
// One multiply lane: registered operand select, then a two-stage partial-product multiplier
`timescale 1ns/100ps

module mul_lane (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  logic                                                 launch,
    input  logic [mul_array_pkg::num_data_words*mul_array_pkg::operand_w-1:0] data_words,
    input  logic [$clog2(mul_array_pkg::num_data_words)-1:0]     lane_sel,
    input  logic [mul_array_pkg::operand_w-1:0]                  lane_coef,
    output logic                                                 prod_valid,
    output logic [mul_array_pkg::product_w-1:0]                  product
);
    import mul_array_pkg::*;

    localparam int grp_n    = 4;
    localparam int grp_size = operand_w / grp_n;

    logic [operand_w-1:0] sel_word;
    logic                 s1_valid;
    logic [operand_w-1:0] s1_data;
    logic [operand_w-1:0] s1_coef;
    logic [operand_w-1:0] pp       [operand_w];
    logic [product_w-1:0] grp_next [grp_n];
    logic                 s2_valid;
    logic [product_w-1:0] s2_grp   [grp_n];

    // Operand pick by select field
    always_comb begin
        case (lane_sel)
            2'd0:    sel_word = data_words[0*operand_w +: operand_w];
            2'd1:    sel_word = data_words[1*operand_w +: operand_w];
            2'd2:    sel_word = data_words[2*operand_w +: operand_w];
            2'd3:    sel_word = data_words[3*operand_w +: operand_w];
            default: sel_word = '0;
        endcase
    end

    // Stage 1, selected word and coefficient
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s1_data  <= '0;
            s1_coef  <= '0;
        end else begin
            s1_valid <= launch;
            s1_data  <= sel_word;
            s1_coef  <= lane_coef;
        end
    end

    // One partial product per coefficient bit, shifted and summed in groups of four
    always_comb begin
        for (int i = 0; i < operand_w; i++) begin
            pp[i] = s1_coef[i] ? s1_data : '0;
        end
        for (int g = 0; g < grp_n; g++) begin
            grp_next[g] = '0;
            for (int j = 0; j < grp_size; j++) begin
                grp_next[g] = grp_next[g] +
                              (product_w'(pp[g*grp_size + j]) << (g*grp_size + j));
            end
        end
    end

    // Stage 2, group sums
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid <= 1'b0;
            for (int g = 0; g < grp_n; g++) begin
                s2_grp[g] <= '0;
            end
        end else begin
            s2_valid <= s1_valid;
            s2_grp   <= grp_next;
        end
    end

    // Stage 3, final unsigned sum
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
            product    <= '0;
        end else begin
            prod_valid <= s2_valid;
            product    <= s2_grp[0] + s2_grp[1] + s2_grp[2] + s2_grp[3];
        end
    end

    a_valid_latency: assert property (
        @(posedge clk) disable iff (!arst_n) prod_valid |-> $past(launch, 3)
    ) else $error("prod_valid without a launch three cycles earlier");

endmodule

// ==== design/product_collector.sv ====
// Captures the lane products and derives busy and done from the count of operations in flight
`timescale 1ns/100ps

module product_collector #(
    parameter int NUM_LANES = 4
) (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          launch,
    input  logic [NUM_LANES-1:0]                          prod_valid,
    input  logic [NUM_LANES*mul_array_pkg::product_w-1:0] product,
    output logic [NUM_LANES*mul_array_pkg::product_w-1:0] results,
    output logic                                          busy,
    output logic                                          done
);
    import mul_array_pkg::*;

    // Latency 4 with starts two cycles apart keeps at most three in flight
    localparam int cnt_w = 3;

    logic [cnt_w-1:0] inflight;
    logic             retire;
    logic             last_retire;

    // Lanes run in lockstep, lane 0 stands for all of them
    assign retire      = prod_valid[0];
    assign last_retire = retire && !launch && (inflight == cnt_w'(1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inflight <= '0;
        end else if (launch && !retire) begin
            inflight <= inflight + 1'b1;
        end else if (!launch && retire) begin
            inflight <= inflight - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (launch) begin
            done <= 1'b0;
        end else if (last_retire) begin
            done <= 1'b1;
        end
    end

    assign busy = (inflight != '0);

    // Result registers, each lane written on its own valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            results <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (prod_valid[i]) begin
                    results[i*product_w +: product_w] <= product[i*product_w +: product_w];
                end
            end
        end
    end

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n) retire |-> (inflight != '0)
    ) else $error("product retired with no operation in flight");

    a_lanes_lockstep: assert property (
        @(posedge clk) disable iff (!arst_n) (prod_valid == '0) || (prod_valid == '1)
    ) else $error("lane valids out of step");

endmodule

// ==== sim/tb_mul_array_model.svh ====
// Multiply array reference model, APB driver tasks and compare tasks, included by the testbench
`ifndef TB_MUL_ARRAY_MODEL_SVH
`define TB_MUL_ARRAY_MODEL_SVH

// Register contents as last written by the host
logic [operand_w-1:0] data_m  [num_data_words];
lane_cfg_u            cfg_m   [n_lanes];
// Products expected from the most recent start
logic [product_w-1:0] exp_res [n_lanes];

// Unsigned product of the selected data word and the lane coefficient
function automatic logic [product_w-1:0] model_product(input int lane);
    lane_cfg_u cfg;
    cfg = cfg_m[lane];
    return product_w'(data_m[cfg.fields.sel]) * product_w'(cfg.fields.coef);
endfunction

// A start freezes the current register contents
task automatic snapshot_model();
    for (int i = 0; i < n_lanes; i++) begin
        exp_res[i] = model_product(i);
    end
endtask

task automatic check_product(input int lane, input logic [product_w-1:0] got,
                             input logic [product_w-1:0] exp);
    if (got !== exp) begin
        report_mismatch($sformatf("lane %0d product 0x%08h, expected 0x%08h", lane, got, exp));
    end
endtask

task automatic check_status(input logic got_busy, input logic got_done,
                            input logic exp_busy, input logic exp_done);
    if (got_busy !== exp_busy || got_done !== exp_done) begin
        report_mismatch($sformatf("status busy=%b done=%b, expected busy=%b done=%b",
                                  got_busy, got_done, exp_busy, exp_done));
    end
endtask

task automatic check_bus_err(input logic [apb_addr_w-1:0] addr, input logic got,
                             input logic exp);
    if (got !== exp) begin
        report_mismatch($sformatf("pslverr=%b at address 0x%02h, expected %b", got, addr, exp));
    end
endtask

// Every access completes without wait states
task automatic check_ready(input logic [apb_addr_w-1:0] addr, input logic got);
    if (got !== 1'b1) begin
        report_mismatch($sformatf("pready=%b at address 0x%02h, expected 1", got, addr));
    end
endtask

task automatic check_readback(input logic [apb_addr_w-1:0] addr,
                              input logic [apb_data_w-1:0] got,
                              input logic [apb_data_w-1:0] exp);
    if (got !== exp) begin
        report_mismatch($sformatf("read 0x%08h at address 0x%02h, expected 0x%08h",
                                  got, addr, exp));
    end
endtask

// Setup phase, then access phase; outputs sampled mid-cycle of the access phase
task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [apb_data_w-1:0] data,
                         input logic exp_err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #drive_delay;
    penable = 1'b1;
    @(negedge clk);
    check_ready(addr, pready);
    check_bus_err(addr, pslverr, exp_err);
    @(posedge clk);
    #drive_delay;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [apb_addr_w-1:0] addr, input logic exp_err,
                        output logic [apb_data_w-1:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #drive_delay;
    penable = 1'b1;
    @(negedge clk);
    data = prdata;
    check_ready(addr, pready);
    check_bus_err(addr, pslverr, exp_err);
    @(posedge clk);
    #drive_delay;
    psel    = 1'b0;
    penable = 1'b0;
endtask

`endif

// ==== sim/tb_mul_array.sv ====
// Testbench top for the multiply array, random and directed APB sequences checked against a model
`timescale 1ns/100ps

module tb_mul_array;
    import mul_array_pkg::*;

    localparam int n_lanes       = 4;
    localparam int drive_delay   = 10;
    localparam int random_runs   = 8;
    // Random runs, directed starts, reset check and bus error check
    localparam int num_sequences = random_runs + 10;

    logic                  clk;
    logic                  arst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    mul_array_top #(
        .NUM_LANES (n_lanes)
    ) UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    `include "tb_mul_array_model.svh"

    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic report_mismatch(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic write_data(input int idx, input logic [operand_w-1:0] val);
        apb_write(addr_data_base + apb_addr_w'(4 * idx), apb_data_w'(val), 1'b0);
        data_m[idx] = val;
    endtask

    task automatic write_cfg(input int lane, input logic [apb_data_w-1:0] raw);
        apb_write(addr_cfg_base + apb_addr_w'(4 * lane), raw, 1'b0);
        cfg_m[lane].raw = raw;
    endtask

    task automatic load_random();
        for (int w = 0; w < num_data_words; w++) begin
            write_data(w, operand_w'($urandom));
        end
        for (int i = 0; i < n_lanes; i++) begin
            write_cfg(i, $urandom);
        end
    endtask

    task automatic start_op();
        apb_write(addr_ctrl, 32'h1, 1'b0);
        snapshot_model();
    endtask

    task automatic expect_status(input logic exp_busy, input logic exp_done);
        logic [apb_data_w-1:0] rd;
        apb_read(addr_status, 1'b0, rd);
        check_status(rd[0], rd[1], exp_busy, exp_done);
    endtask

    // Poll status until done, bounded so a stuck FSM shows up quickly
    task automatic wait_done();
        logic [apb_data_w-1:0] rd;
        int polls;
        rd    = '0;
        polls = 0;
        while (!rd[1]) begin
            if (polls == 10) begin
                $display("done never came up after %0d status polls", polls);
                stop_with_failure();
            end else begin
                apb_read(addr_status, 1'b0, rd);
                polls++;
            end
        end
        check_status(rd[0], rd[1], 1'b0, 1'b1);
    endtask

    task automatic check_results();
        logic [apb_data_w-1:0] rd;
        for (int i = 0; i < n_lanes; i++) begin
            apb_read(addr_result_base + apb_addr_w'(4 * i), 1'b0, rd);
            check_product(i, rd, exp_res[i]);
        end
    endtask

    task automatic check_registers();
        logic [apb_data_w-1:0] rd;
        for (int w = 0; w < num_data_words; w++) begin
            apb_read(addr_data_base + apb_addr_w'(4 * w), 1'b0, rd);
            check_readback(addr_data_base + apb_addr_w'(4 * w), rd, apb_data_w'(data_m[w]));
        end
        for (int i = 0; i < n_lanes; i++) begin
            apb_read(addr_cfg_base + apb_addr_w'(4 * i), 1'b0, rd);
            check_readback(addr_cfg_base + apb_addr_w'(4 * i), rd, cfg_m[i].raw);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(num_sequences * 40 * 100);
        $display("Timeout, the run did not finish within %0d clock cycles", num_sequences * 40);
        stop_with_failure();
    end

    initial begin
        logic [apb_data_w-1:0] rd;
        lane_cfg_u             cfg;
        logic [operand_w-1:0]  edge_vals [3];
        logic [apb_addr_w-1:0] bad_addrs [9];
        void'($urandom(36));
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int w = 0; w < num_data_words; w++) begin
            data_m[w] = '0;
        end
        for (int i = 0; i < n_lanes; i++) begin
            cfg_m[i].raw = '0;
            exp_res[i]   = '0;
        end
        repeat (5) @(posedge clk);
        #drive_delay;
        arst_n = 1'b1;

        // Everything idle and zero out of reset
        expect_status(1'b0, 1'b0);
        check_results();
        check_registers();

        repeat (random_runs) begin
            load_random();
            start_op();
            expect_status(1'b1, 1'b0);
            wait_done();
            check_results();
        end

        // Corner operands 0, 1 and 0xFFFF against each other
        edge_vals[0] = 16'h0000;
        edge_vals[1] = 16'h0001;
        edge_vals[2] = 16'hFFFF;
        for (int w = 0; w < num_data_words; w++) begin
            write_data(w, edge_vals[(w < 3) ? w : 2]);
        end
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < n_lanes; i++) begin
                cfg.raw         = '0;
                cfg.fields.sel  = 2'(i);
                cfg.fields.coef = (i == 3) ? 16'hFFFF : edge_vals[k];
                write_cfg(i, cfg.raw);
            end
            start_op();
            wait_done();
            check_results();
        end

        // Overlapping starts, operands changed while the first one runs
        load_random();
        start_op();
        write_data($urandom % num_data_words, operand_w'($urandom));
        write_cfg($urandom % n_lanes, $urandom);
        start_op();
        start_op();
        expect_status(1'b1, 1'b0);
        wait_done();
        check_results();
        check_registers();

        // Unmapped, unaligned and read-only addresses
        bad_addrs = '{8'h02, 8'h13, 8'h20, 8'h3C, 8'h48, 8'h4C, 8'h7C, 8'h90, 8'hFC};
        for (int a = 0; a < 9; a++) begin
            apb_write(bad_addrs[a], $urandom, 1'b1);
            apb_read(bad_addrs[a], 1'b1, rd);
        end
        apb_write(addr_status, $urandom, 1'b1);
        for (int i = 0; i < n_lanes; i++) begin
            apb_write(addr_result_base + apb_addr_w'(4 * i), $urandom, 1'b1);
        end
        // Control write without the start bit
        apb_write(addr_ctrl, 32'h2, 1'b0);
        expect_status(1'b0, 1'b1);
        check_registers();
        check_results();

        // A new start drops done until its own results land
        load_random();
        start_op();
        expect_status(1'b1, 1'b0);
        wait_done();
        expect_status(1'b0, 1'b1);
        start_op();
        expect_status(1'b1, 1'b0);
        wait_done();
        check_results();

        $display("Simulation PASSED");
        $finish;
    end

endmodule
